// File: source/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // result slots per instruction
    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

    localparam int DATA_W    = 64;  // slot value
    localparam int ADDR_W    = 32;  // destination / memory address
    localparam int REG_IDX_W = 3;   // register index taken from dest[2:0]

    // what the instruction asks writeback to do beyond the slot writes
    typedef enum logic [2:0] {
        OP_PLAIN    = 3'd0,
        OP_BRANCH   = 3'd1,
        OP_JUMP_FAR = 3'd2, // eip comes from slot 1
        OP_RET_FAR  = 3'd3, // eip comes from slot 1
        OP_HALT     = 3'd4
    } wb_op_t;

    // target of one result slot
    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_REG  = 2'd1,
        KIND_SEG  = 2'd2,
        KIND_MEM  = 2'd3
    } slot_kind_t;

    // [2:0] exception code, [3] interrupt
    typedef logic [3:0] exc_type_t;

endpackage

`default_nettype wire

// File: source/wb_if.sv
`default_nettype none

// per-slot register write bundle, one per register file
interface reg_write_if import wb_pkg::*; #(
    parameter int REG_W = 32
) ();
    logic [NUM_SLOTS-1:0]                ld;
    logic [NUM_SLOTS-1:0][REG_IDX_W-1:0] addr;
    logic [NUM_SLOTS-1:0][REG_W-1:0]     data;  // truncated slot values

    modport source (output ld, output addr, output data);
    modport sink   (input ld, input addr, input data);
endinterface

// single memory write per instruction into the write queue
interface mem_write_if import wb_pkg::*; ();
    logic              push;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [1:0]        size;
    logic              full;  // driven back by the queue

    modport source (output push, output addr, output data, output size, input full);
    modport sink   (input push, input addr, input data, input size, output full);
endinterface

`default_nettype wire

// File: source/writeback_stage.sv
`default_nettype none

module writeback_stage import wb_pkg::*; #(
    parameter int GPR_W = 32,
    parameter int SEG_W = 16
) (
    input  logic                            valid,
    input  wb_op_t                          op,
    input  logic [NUM_SLOTS-1:0][DATA_W-1:0] slot_val,
    input  logic [NUM_SLOTS-1:0][ADDR_W-1:0] slot_dest,
    input  slot_kind_t [NUM_SLOTS-1:0]      slot_kind,
    input  logic [NUM_SLOTS-1:0]            slot_wb,
    input  logic [1:0]                      size,
    input  logic [ADDR_W-1:0]               eip,
    input  logic [ADDR_W-1:0]               br_fip,
    input  logic                            br_taken,
    input  logic                            br_correct,
    input  logic                            exc,
    input  exc_type_t                       exc_type,
    input  logic                            interrupt,
    reg_write_if.source                     gpr,
    reg_write_if.source                     seg,
    mem_write_if.source                     mem,
    output logic                            valid_out,
    output logic                            stall,
    output logic [ADDR_W-1:0]               new_eip,
    output logic [ADDR_W-1:0]               new_fip_even,
    output logic [ADDR_W-1:0]               new_fip_odd,
    output logic                            resteer,
    output logic                            exc_valid,
    output exc_type_t                       exc_type_out,
    output logic                            halt_set
);

    logic                  exc_any;
    logic [NUM_SLOTS-1:0]  mem_req;   // memory slots before final validity
    logic [NUM_SLOTS-1:0]  mem_ld;
    logic [SLOT_IDX_W-1:0] mem_sel;
    logic                  ld_eip;    // far transfer, eip from slot 1
    logic [ADDR_W-1:0]     line_base;
    logic [ADDR_W-1:0]     line_next;

    assign exc_any = exc | interrupt;

    // the queue can take nothing this cycle, hold the instruction
    assign stall     = mem.full & (|mem_req);
    assign valid_out = valid & ~stall & ~exc_any;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        assign mem_req[i] = valid & slot_wb[i] & (slot_kind[i] == KIND_MEM);
        assign mem_ld[i]  = valid_out & slot_wb[i] & (slot_kind[i] == KIND_MEM);

        assign gpr.ld[i]   = valid_out & slot_wb[i] & (slot_kind[i] == KIND_REG);
        assign gpr.addr[i] = slot_dest[i][REG_IDX_W-1:0];
        assign gpr.data[i] = slot_val[i][GPR_W-1:0];

        assign seg.ld[i]   = valid_out & slot_wb[i] & (slot_kind[i] == KIND_SEG);
        assign seg.addr[i] = slot_dest[i][REG_IDX_W-1:0];
        assign seg.data[i] = slot_val[i][SEG_W-1:0];
    end

    // lowest memory slot wins, only one store per instruction
    always_comb begin
        mem_sel = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_ld[i]) begin
                mem_sel = SLOT_IDX_W'(i);
            end
        end
    end

    assign mem.push = |mem_ld;
    assign mem.addr = slot_dest[mem_sel];
    assign mem.data = slot_val[mem_sel];
    assign mem.size = size;

    // next eip
    assign ld_eip = (op == OP_JUMP_FAR) || (op == OP_RET_FAR);

    always_comb begin
        if (ld_eip) begin
            new_eip = slot_val[1][ADDR_W-1:0];
        end else if (br_taken) begin
            new_eip = br_fip;
        end else begin
            new_eip = eip;
        end
    end

    // fetch lines are 16 bytes, bit 4 says which bank holds the target
    assign line_base = {new_eip[ADDR_W-1:4], 4'h0};
    assign line_next = line_base + ADDR_W'(16);

    assign new_fip_even = new_eip[4] ? line_next : line_base;
    assign new_fip_odd  = new_eip[4] ? line_base : line_next;

    assign resteer = valid & ~br_correct;  // mispredict

    assign exc_valid    = valid & exc_any;
    assign exc_type_out = exc_valid ? {interrupt, exc_type[2:0]} : '0;

    assign halt_set = valid_out & (op == OP_HALT);

endmodule

`default_nettype wire

// File: source/arch_reg_file.sv
`default_nettype none

module arch_reg_file import wb_pkg::*; #(
    parameter int REG_COUNT = 8,
    parameter int REG_W     = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [REG_IDX_W-1:0] rd_addr,
    reg_write_if.sink            wr,
    output logic [REG_W-1:0]     rd_data
);

    logic [REG_W-1:0] regs [REG_COUNT];

    // architectural state, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later slots override earlier ones on the same index
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (wr.ld[s]) begin
                    regs[wr.addr[s]] <= wr.data[s];
                end
            end
        end
    end

    assign rd_data = regs[rd_addr];  // async read

endmodule

`default_nettype wire

// File: source/mem_write_queue.sv
`default_nettype none

module mem_write_queue import wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              drain,
    mem_write_if.sink         in,
    output logic              out_valid,
    output logic [ADDR_W-1:0] out_addr,
    output logic [DATA_W-1:0] out_data,
    output logic [1:0]        out_size
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    logic [ADDR_W-1:0] addr_q [QUEUE_DEPTH];
    logic [DATA_W-1:0] data_q [QUEUE_DEPTH];
    logic [1:0]        size_q [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign in.full   = (count == (PTR_W + 1)'(QUEUE_DEPTH));
    assign out_valid = (count != '0);

    assign do_push = in.push & ~in.full;
    assign do_pop  = out_valid & drain;  // drain low holds the head

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_q[wr_ptr] <= in.addr;
            data_q[wr_ptr] <= in.data;
            size_q[wr_ptr] <= in.size;
        end
    end

    assign out_addr = addr_q[rd_ptr];
    assign out_data = data_q[rd_ptr];
    assign out_size = size_q[rd_ptr];

endmodule

`default_nettype wire

// File: source/wb_top.sv
`default_nettype none

module wb_top import wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int REG_COUNT   = 8,
    parameter int GPR_W       = 32,
    parameter int SEG_W       = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             valid_in,
    input  wb_op_t                           op,
    input  logic [NUM_SLOTS-1:0][DATA_W-1:0] slot_val,
    input  logic [NUM_SLOTS-1:0][ADDR_W-1:0] slot_dest,
    input  slot_kind_t [NUM_SLOTS-1:0]       slot_kind,
    input  logic [NUM_SLOTS-1:0]             slot_wb,
    input  logic [1:0]                       size,
    input  logic [ADDR_W-1:0]                eip,
    input  logic [ADDR_W-1:0]                br_fip,
    input  logic                             br_taken,
    input  logic                             br_correct,
    input  logic                             exc,
    input  exc_type_t                        exc_type,
    input  logic                             interrupt,
    input  logic [REG_IDX_W-1:0]             gpr_rd_addr,
    input  logic [REG_IDX_W-1:0]             seg_rd_addr,
    input  logic                             mq_drain,
    output logic [GPR_W-1:0]                 gpr_rd_data,
    output logic [SEG_W-1:0]                 seg_rd_data,
    output logic                             mq_valid,
    output logic [ADDR_W-1:0]                mq_addr,
    output logic [DATA_W-1:0]                mq_data,
    output logic [1:0]                       mq_size,
    output logic                             halted,
    output logic                             valid_out,
    output logic                             stall,
    output logic [ADDR_W-1:0]                new_eip,
    output logic [ADDR_W-1:0]                new_fip_even,
    output logic [ADDR_W-1:0]                new_fip_odd,
    output logic                             resteer,
    output logic                             exc_valid,
    output exc_type_t                        exc_type_out
);

    logic halt_set;

    reg_write_if #(.REG_W(GPR_W)) gpr_wr ();
    reg_write_if #(.REG_W(SEG_W)) seg_wr ();
    mem_write_if                  mem_wr ();

    writeback_stage #(
        .GPR_W(GPR_W),
        .SEG_W(SEG_W)
    ) stage_i (
        .valid(valid_in), .op(op), .slot_val(slot_val), .slot_dest(slot_dest),
        .slot_kind(slot_kind), .slot_wb(slot_wb), .size(size), .eip(eip),
        .br_fip(br_fip), .br_taken(br_taken), .br_correct(br_correct), .exc(exc),
        .exc_type(exc_type), .interrupt(interrupt),
        .gpr(gpr_wr.source), .seg(seg_wr.source), .mem(mem_wr.source),
        .valid_out(valid_out), .stall(stall), .new_eip(new_eip),
        .new_fip_even(new_fip_even), .new_fip_odd(new_fip_odd), .resteer(resteer),
        .exc_valid(exc_valid), .exc_type_out(exc_type_out), .halt_set(halt_set)
    );

    arch_reg_file #(.REG_COUNT(REG_COUNT), .REG_W(GPR_W)) gpr_file (
        .clk(clk), .reset(reset), .rd_addr(gpr_rd_addr), .wr(gpr_wr.sink),
        .rd_data(gpr_rd_data)
    );

    arch_reg_file #(.REG_COUNT(REG_COUNT), .REG_W(SEG_W)) seg_file (
        .clk(clk), .reset(reset), .rd_addr(seg_rd_addr), .wr(seg_wr.sink),
        .rd_data(seg_rd_data)
    );

    mem_write_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) mem_queue (
        .clk(clk), .reset(reset), .drain(mq_drain), .in(mem_wr.sink),
        .out_valid(mq_valid), .out_addr(mq_addr), .out_data(mq_data), .out_size(mq_size)
    );

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt_set) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: tests/wb_checker.sv
`default_nettype none

module wb_checker import wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic clk, reset, valid_in, br_taken, br_correct, exc, interrupt, mq_drain,
    input  wb_op_t                           op,
    input  logic [NUM_SLOTS-1:0][DATA_W-1:0] slot_val,
    input  logic [NUM_SLOTS-1:0][ADDR_W-1:0] slot_dest,
    input  slot_kind_t [NUM_SLOTS-1:0]       slot_kind,
    input  logic [NUM_SLOTS-1:0]             slot_wb,
    input  logic [1:0]                       size, mq_size,
    input  logic [ADDR_W-1:0] eip, br_fip, mq_addr, new_eip, new_fip_even, new_fip_odd,
    input  exc_type_t                        exc_type, exc_type_out,
    input  logic [REG_IDX_W-1:0]             gpr_rd_addr, seg_rd_addr,
    input  logic [31:0]                      gpr_rd_data,
    input  logic [15:0]                      seg_rd_data,
    input  logic [DATA_W-1:0]                mq_data,
    input  logic mq_valid, halted, valid_out, stall, resteer, exc_valid,
    output int                               error_count,
    output int                               check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [1:0]        size;
    } mq_entry_t;

    logic [31:0]       gpr_model [8];
    logic [15:0]       seg_model [8];
    mq_entry_t         mq_model [$];  // oldest entry at the front
    logic              halted_model;
    logic              mem_any;
    int                mem_slot;
    logic              exp_stall;
    logic              exp_valid;
    logic              exp_exc;
    logic [ADDR_W-1:0] exp_eip;

    // far transfers beat a taken branch
    function automatic logic [ADDR_W-1:0] expected_eip(wb_op_t o, logic [ADDR_W-1:0] far,
            logic [ADDR_W-1:0] seq, logic [ADDR_W-1:0] target, logic taken);
        if (o == OP_JUMP_FAR || o == OP_RET_FAR) begin
            return far;
        end
        return taken ? target : seq;
    endfunction

    task automatic compare_value(string name, logic [63:0] exp, logic [63:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error %0d ns: %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 8; r++) begin
                gpr_model[r] = '0;
                seg_model[r] = '0;
            end
            mq_model.delete();
            halted_model = 1'b0;
        end else begin
            mem_any  = 1'b0;
            mem_slot = 0;
            for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
                if (slot_wb[i] && slot_kind[i] == KIND_MEM) begin
                    mem_any  = 1'b1;
                    mem_slot = i;  // ends on the lowest store slot
                end
            end
            exp_stall = valid_in && mem_any && (mq_model.size() == QUEUE_DEPTH);
            exp_exc   = valid_in && (exc || interrupt);
            exp_valid = valid_in && !exp_stall && !exc && !interrupt;
            exp_eip   = expected_eip(op, slot_val[1][ADDR_W-1:0], eip, br_fip, br_taken);

            compare_value("stall", exp_stall, stall);
            compare_value("valid_out", exp_valid, valid_out);
            compare_value("new_eip", exp_eip, new_eip);
            compare_value("new_fip_odd", {exp_eip[31:5], 5'h10}, new_fip_odd);
            compare_value("new_fip_even", {exp_eip[31:5] + 27'(exp_eip[4]), 5'h00},
                          new_fip_even);
            compare_value("resteer", valid_in && !br_correct, resteer);
            compare_value("exc_valid", exp_exc, exc_valid);
            compare_value("exc_type_out", exp_exc ? {interrupt, exc_type[2:0]} : 4'h0,
                          exc_type_out);
            compare_value("halted", halted_model, halted);
            compare_value("gpr_rd_data", gpr_model[gpr_rd_addr], gpr_rd_data);
            compare_value("seg_rd_data", seg_model[seg_rd_addr], seg_rd_data);
            compare_value("mq_valid", mq_model.size() != 0, mq_valid);
            if (mq_model.size() != 0) begin
                compare_value("mq_addr", mq_model[0].addr, mq_addr);
                compare_value("mq_data", mq_model[0].data, mq_data);
                compare_value("mq_size", mq_model[0].size, mq_size);
            end

            // state the DUT takes on this edge
            if (mq_drain && mq_model.size() != 0) begin
                void'(mq_model.pop_front());
            end
            if (exp_valid) begin
                for (int i = 0; i < NUM_SLOTS; i++) begin
                    if (slot_wb[i] && slot_kind[i] == KIND_REG) begin
                        gpr_model[slot_dest[i][2:0]] = slot_val[i][31:0];
                    end
                    if (slot_wb[i] && slot_kind[i] == KIND_SEG) begin
                        seg_model[slot_dest[i][2:0]] = slot_val[i][15:0];
                    end
                end
                if (mem_any) begin
                    mq_model.push_back({slot_dest[mem_slot], slot_val[mem_slot], size});
                end
                if (op == OP_HALT) begin
                    halted_model = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/wb_tb.sv
`default_nettype none

module wb_tb import wb_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int QUEUE_DEPTH = 4;

    logic clk, reset, valid_in, br_taken, br_correct, exc, interrupt, mq_drain;
    wb_op_t                           op;
    logic [NUM_SLOTS-1:0][DATA_W-1:0] slot_val;
    logic [NUM_SLOTS-1:0][ADDR_W-1:0] slot_dest;
    slot_kind_t [NUM_SLOTS-1:0]       slot_kind;
    logic [NUM_SLOTS-1:0]             slot_wb;
    logic [1:0]                       size, mq_size;
    logic [ADDR_W-1:0] eip, br_fip, mq_addr, new_eip, new_fip_even, new_fip_odd;
    exc_type_t                        exc_type, exc_type_out;
    logic [REG_IDX_W-1:0]             gpr_rd_addr, seg_rd_addr;
    logic [31:0]                      gpr_rd_data;
    logic [15:0]                      seg_rd_data;
    logic [DATA_W-1:0]                mq_data;
    logic mq_valid, halted, valid_out, stall, resteer, exc_valid;
    int error_count, check_count;
    int seed = 32'hcb95;
    bit timed_out;

    wb_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) wb_top_i (.*);
    wb_checker #(.QUEUE_DEPTH(QUEUE_DEPTH)) checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // mostly valid, with the odd exception or interrupt
    task automatic drive_random(bit allow_mem);
        valid_in = ($random(seed) & 7) != 0;
        op       = wb_op_t'(3'($random(seed) & 3));  // no halt here
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_val[i]  = {$random(seed), $random(seed)};
            slot_dest[i] = $random(seed);
            slot_kind[i] = slot_kind_t'(2'($random(seed)));
            if (!allow_mem && slot_kind[i] == KIND_MEM) begin
                slot_kind[i] = KIND_REG;
            end
        end
        slot_wb     = NUM_SLOTS'($random(seed));
        size        = 2'($random(seed));
        eip         = $random(seed);
        br_fip      = $random(seed);
        br_taken    = 1'($random(seed));
        br_correct  = 1'($random(seed));
        exc         = ($random(seed) & 7) == 0;
        interrupt   = ($random(seed) & 15) == 0;
        exc_type    = 4'($random(seed));
        gpr_rd_addr = REG_IDX_W'($random(seed));
        seg_rd_addr = REG_IDX_W'($random(seed));
        mq_drain    = 1'($random(seed));
    endtask

    task automatic drive_store();
        drive_random(1'b1);
        valid_in     = 1'b1;
        exc          = 1'b0;
        interrupt    = 1'b0;
        slot_kind[0] = KIND_MEM;
        slot_wb[0]   = 1'b1;
        mq_drain     = 1'b0;  // hold the queue
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        valid_in = 1'b0;
        mq_drain = 1'b1;
        while (mq_valid && n < 4 * QUEUE_DEPTH + 10) begin
            @(negedge clk);
            n++;
        end
        if (mq_valid) begin
            timed_out = 1'b1;
            $display("Timeout: write queue did not drain");
        end
    endtask

    task automatic run_tests();
        int n;
        repeat (300) begin
            @(negedge clk);
            drive_random(1'b1);
        end
        @(negedge clk);
        wait_drained();
        if (timed_out) return;
        // fill the queue until stores stall
        n = 0;
        do begin
            @(negedge clk);
            drive_store();
            @(posedge clk);
            n++;
        end while (!stall && n < 2 * QUEUE_DEPTH + 2);
        if (!stall) begin
            timed_out = 1'b1;
            $display("Timeout: stall never rose with the write queue held");
            return;
        end
        repeat (3) begin
            @(negedge clk);
            drive_store();
        end
        @(negedge clk);
        wait_drained();
        if (timed_out) return;
        for (int r = 0; r < 8; r++) begin  // read back every register
            @(negedge clk);
            gpr_rd_addr = REG_IDX_W'(r);
            seg_rd_addr = REG_IDX_W'(r);
        end
        @(negedge clk);
        drive_random(1'b0);
        valid_in  = 1'b1;
        op        = OP_HALT;
        exc       = 1'b0;
        interrupt = 1'b0;
        repeat (20) begin
            @(negedge clk);
            drive_random(1'b1);
        end
        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset    = 1'b0;
        valid_in = 1'b0;
        repeat (5) @(negedge clk);
    endtask

    task automatic finish_run();
        @(negedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        timed_out = 1'b0;
        drive_random(1'b1);
        valid_in = 1'b0;
        mq_drain = 1'b1;
        reset    = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_tests();
        finish_run();
    end

endmodule

`default_nettype wire

// File: sim.f
source/wb_pkg.sv
source/wb_if.sv
source/writeback_stage.sv
source/arch_reg_file.sv
source/mem_write_queue.sv
source/wb_top.sv
tests/wb_checker.sv
tests/wb_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= wb_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

SOURCES := $(wildcard source/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
